//--- compile.f
src/gba_bus_pkg.sv
src/gba_periph_pkg.sv
src/reset_sequencer.sv
src/io_bus_ctrl.sv
src/interrupt_ctrl.sv
src/timer_unit.sv
src/keypad_regs.sv
src/gba_io_top.sv
tests/tb_gba_io.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_gba_io
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_gba_io.sv
/*
 * Directed testbench for the I/O side: reset sequencing, bus path,
 * keypad, interrupt controller and timers
 */
`timescale 1ns/1ps

module tb_gba_io;

    localparam int RESET_HOLD = 8;
    localparam int MAX_CYCLES = 3000;

    logic                         clk16;
    logic                         resetn;
    logic                         loading;
    gba_periph_pkg::pad_buttons_t pad_btns;
    logic [2:0]                   irq_video;
    gba_bus_pkg::io_addr_t        bus_addr;
    gba_bus_pkg::io_acc_e         bus_acc;
    logic                         bus_rnw;
    logic                         bus_ena;
    gba_bus_pkg::io_data_t        bus_wdata;
    gba_bus_pkg::io_data_t        bus_rdata;
    logic                         bus_done;
    logic                         cpu_irq;
    logic                         halt;
    logic                         gba_on;

    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    integer seed   = 32'h9105_27c2;

    gba_io_top #(.RESET_HOLD(RESET_HOLD), .NUM_TIMERS(4)) dut_i (
        .clk16(clk16), .resetn(resetn), .loading(loading), .pad_btns(pad_btns),
        .irq_video(irq_video), .bus_addr(bus_addr), .bus_acc(bus_acc),
        .bus_rnw(bus_rnw), .bus_ena(bus_ena), .bus_wdata(bus_wdata),
        .bus_rdata(bus_rdata), .bus_done(bus_done), .cpu_irq(cpu_irq),
        .halt(halt), .gba_on(gba_on)
    );

    initial clk16 = 1'b0;
    always #20 clk16 = ~clk16;

    always @(posedge clk16) begin                   // run limit
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped, no result after %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks and reference rules
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input gba_bus_pkg::io_data_t got,
                              input gba_bus_pkg::io_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // pad buttons to console keys, pressed = 1
    function automatic gba_periph_pkg::key_state_t pad_to_keys(
        input gba_periph_pkg::pad_buttons_t p);
        gba_periph_pkg::key_state_t k;
        k[0] = p[8];    // A
        k[1] = p[0];    // B
        k[2] = p[2];    // SELECT
        k[3] = p[3];    // START
        k[4] = p[7];    // RIGHT
        k[5] = p[6];    // LEFT
        k[6] = p[4];    // UP
        k[7] = p[5];    // DOWN
        k[8] = p[11];   // R
        k[9] = p[10];   // L
        return k;
    endfunction

    // read word at 0x200: IF in the upper half
    function automatic gba_bus_pkg::io_data_t irq_word(input logic [13:0] ie,
                                                        input logic [13:0] iflags);
        return {2'b00, iflags, 2'b00, ie};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bus access
    //////////////////////////////////////////////////////////////////////

    task automatic bus_access(input gba_bus_pkg::io_addr_t addr,
                              input gba_bus_pkg::io_acc_e acc, input logic rnw,
                              input gba_bus_pkg::io_data_t wdata,
                              output gba_bus_pkg::io_data_t rdata);
        int n;
        n = 0;
        @(negedge clk16);
        bus_addr  = addr;
        bus_acc   = acc;
        bus_rnw   = rnw;
        bus_wdata = wdata;
        bus_ena   = 1'b1;
        while (n == 0 || (!bus_done && n < 8)) begin
            @(negedge clk16);
            bus_ena = 1'b0;
            n++;
        end
        rdata = bus_rdata;
        checks++;
        if (!bus_done) begin
            errors++;
            $display("bus access to %h got no bus_done within 8 cycles", addr);
        end else if (n != 1) begin
            errors++;
            $display("bus_done for %h came %0d cycles after bus_ena, not 1", addr, n);
        end
    endtask

    task automatic bus_write(input gba_bus_pkg::io_addr_t addr,
                             input gba_bus_pkg::io_acc_e acc,
                             input gba_bus_pkg::io_data_t wdata);
        gba_bus_pkg::io_data_t unused;
        bus_access(addr, acc, 1'b0, wdata, unused);
    endtask

    task automatic bus_read(input gba_bus_pkg::io_addr_t addr,
                            output gba_bus_pkg::io_data_t rdata);
        bus_access(addr, gba_bus_pkg::acc_word, 1'b1, '0, rdata);
    endtask

    task automatic pulse_video(input int idx);
        @(negedge clk16);
        irq_video[idx] = 1'b1;
        @(negedge clk16);
        irq_video = '0;
    endtask

    // polls IF until bit idx is set, 20 reads span 40 cycles
    task automatic wait_for_if(input int idx, output gba_bus_pkg::io_data_t word);
        int n;
        n = 0;
        word = '0;
        while (!word[16 + idx] && n < 20) begin
            bus_read(10'h200, word);
            n++;
        end
        checks++;
        if (!word[16 + idx]) begin
            errors++;
            $display("IF bit %0d was not set within 40 cycles", idx);
        end
    endtask

    // rising edge of gba_on is seen RESET_HOLD+1 falling edges after release
    task automatic wait_gba_on(input string what);
        int n;
        n = 0;
        while (!gba_on && n < 4 * RESET_HOLD) begin
            @(negedge clk16);
            n++;
        end
        checks++;
        if (n != RESET_HOLD + 1) begin
            errors++;
            $display("gba_on rose %0d cycles after %s, expected %0d", n, what,
                     RESET_HOLD + 1);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-10s finished, %0d errors", name, errors - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (3) @(negedge clk16);
        check_bit("bus_done", bus_done, 1'b0);
        check_bit("cpu_irq", cpu_irq, 1'b0);
        check_bit("halt", halt, 1'b0);
        check_bit("gba_on", gba_on, 1'b0);
        resetn = 1'b1;
        wait_gba_on("reset release");
        @(negedge clk16);
        loading = 1'b1;
        @(negedge clk16);
        check_bit("gba_on", gba_on, 1'b0);             // dropped at the next edge
        repeat (3) @(negedge clk16);
        loading = 1'b0;
        wait_gba_on("end of loading");
        report_test("reset", e0);
    endtask

    task automatic test_bus();
        gba_bus_pkg::io_data_t rd;
        int e0;
        e0 = errors;
        bus_write(10'h200, gba_bus_pkg::acc_half, 32'h0000_1234);
        check_bit("bus_done", bus_done, 1'b1);
        @(negedge clk16);
        check_bit("bus_done", bus_done, 1'b0);         // one cycle wide
        bus_read(10'h200, rd);
        check_data("IE", rd, irq_word(14'h1234, '0));
        bus_write(10'h201, gba_bus_pkg::acc_byte, 32'h0000_2a00);
        bus_read(10'h200, rd);
        check_data("IE", rd, irq_word(14'h2a34, '0));  // low byte kept
        bus_write(10'h200, gba_bus_pkg::acc_half, '0);
        bus_read(10'h004, rd);
        check_data("unmapped 0x004", rd, '0);
        bus_read(10'h110, rd);
        check_data("unmapped 0x110", rd, '0);
        bus_read(10'h3fc, rd);
        check_data("unmapped 0x3fc", rd, '0);
        report_test("bus", e0);
    endtask

    task automatic test_keypad();
        gba_bus_pkg::io_data_t rd;
        int e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk16);
            pad_btns = gba_periph_pkg::pad_buttons_t'($random(seed));
            repeat (2) @(negedge clk16);
            bus_read(10'h130, rd);
            check_data("KEYINPUT", rd, {22'd0, ~pad_to_keys(pad_btns)});
        end
        @(negedge clk16);
        pad_btns = '0;
        bus_write(10'h202, gba_bus_pkg::acc_half, 32'h3fff_0000);
        // OR mode on A and B
        bus_write(10'h132, gba_bus_pkg::acc_half, 32'h4003_0000);
        pad_btns = 12'h004;                            // SELECT, not in the mask
        repeat (5) @(negedge clk16);
        bus_read(10'h200, rd);
        check_data("IF", rd, irq_word('0, '0));
        pad_btns = 12'h001;                            // B
        repeat (5) @(negedge clk16);
        bus_read(10'h200, rd);
        check_data("IF", rd, irq_word('0, 14'h1000));
        bus_write(10'h202, gba_bus_pkg::acc_half, 32'h1000_0000);
        // AND mode, B alone is not enough
        bus_write(10'h132, gba_bus_pkg::acc_half, 32'hc003_0000);
        repeat (5) @(negedge clk16);
        bus_read(10'h200, rd);
        check_data("IF", rd, irq_word('0, '0));
        pad_btns = 12'h101;                            // A and B
        repeat (5) @(negedge clk16);
        bus_read(10'h200, rd);
        check_data("IF", rd, irq_word('0, 14'h1000));
        pad_btns = '0;
        bus_write(10'h132, gba_bus_pkg::acc_half, '0);
        bus_write(10'h202, gba_bus_pkg::acc_half, 32'h3fff_0000);
        report_test("keypad", e0);
    endtask

    task automatic test_interrupts();
        gba_bus_pkg::io_data_t rd;
        int e0;
        e0 = errors;
        pulse_video(0);
        bus_read(10'h200, rd);
        check_data("IF", rd, irq_word('0, 14'h0001));
        check_bit("cpu_irq", cpu_irq, 1'b0);
        bus_write(10'h200, gba_bus_pkg::acc_half, 32'h0000_0001);
        @(negedge clk16);
        check_bit("cpu_irq", cpu_irq, 1'b0);           // IME still off
        bus_write(10'h208, gba_bus_pkg::acc_half, 32'h0000_0001);
        @(negedge clk16);
        check_bit("cpu_irq", cpu_irq, 1'b1);
        bus_write(10'h202, gba_bus_pkg::acc_half, 32'h0001_0000);
        @(negedge clk16);
        check_bit("cpu_irq", cpu_irq, 1'b0);
        bus_read(10'h200, rd);
        check_data("IF", rd, irq_word(14'h0001, '0));
        // halt, then wake on an enabled source only
        bus_write(10'h301, gba_bus_pkg::acc_byte, '0);
        check_bit("halt", halt, 1'b1);
        repeat (3) @(negedge clk16);
        check_bit("halt", halt, 1'b1);
        pulse_video(1);                                // hblank is masked
        repeat (2) @(negedge clk16);
        check_bit("halt", halt, 1'b1);
        pulse_video(0);
        @(negedge clk16);
        check_bit("halt", halt, 1'b0);
        check_bit("cpu_irq", cpu_irq, 1'b1);
        bus_write(10'h200, gba_bus_pkg::acc_word, 32'h3fff_0000);
        bus_write(10'h208, gba_bus_pkg::acc_half, '0);
        report_test("interrupts", e0);
    endtask

    task automatic test_timers();
        gba_bus_pkg::io_data_t rd;
        gba_periph_pkg::timer_count_t cnt;
        int e0;
        e0 = errors;
        bus_write(10'h100, gba_bus_pkg::acc_word, 32'h00c0_fff0); // div1, irq, on
        wait_for_if(gba_periph_pkg::irq_timer0, rd);
        bus_read(10'h100, rd);
        cnt = rd[15:0];
        for (int i = 0; i < 5; i++) begin
            // reads are two cycles apart, counter wraps to the reload
            for (int s = 0; s < 2; s++)
                cnt = (cnt == 16'hffff) ? 16'hfff0 : cnt + 16'd1;
            bus_read(10'h100, rd);
            check_data("TM0", rd, {8'h00, 8'hc0, cnt});
        end
        // timer 1 counts timer 0 overflows
        bus_write(10'h100, gba_bus_pkg::acc_word, 32'h0000_fff0);
        bus_write(10'h104, gba_bus_pkg::acc_word, 32'h00c4_fffe);
        bus_write(10'h202, gba_bus_pkg::acc_half, 32'h3fff_0000);
        bus_write(10'h100, gba_bus_pkg::acc_word, 32'h00c0_fff0);
        wait_for_if(gba_periph_pkg::irq_timer0, rd);
        check_data("IF", rd, irq_word('0, 14'h0008));  // one overflow, no timer 1
        bus_read(10'h104, rd);
        check_data("TM1", rd, 32'h00c4_ffff);
        bus_write(10'h202, gba_bus_pkg::acc_half, 32'h0008_0000);
        wait_for_if(gba_periph_pkg::irq_timer0, rd);
        check_data("IF", rd, irq_word('0, 14'h0018));
        bus_write(10'h100, gba_bus_pkg::acc_word, '0);
        bus_write(10'h104, gba_bus_pkg::acc_word, '0);
        report_test("timers", e0);
    endtask

    initial begin
        resetn    = 1'b0;
        loading   = 1'b0;
        pad_btns  = '0;
        irq_video = '0;
        bus_addr  = '0;
        bus_acc   = gba_bus_pkg::acc_word;
        bus_rnw   = 1'b1;
        bus_ena   = 1'b0;
        bus_wdata = '0;

        test_reset();
        test_bus();
        test_keypad();
        test_interrupts();
        test_timers();

        $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- src/gba_io_top.sv
/*
 * I/O side of the console core: reset sequencer, bus path,
 * interrupt controller, timers and keypad
 */
`timescale 1ns/1ps

module gba_io_top #(
    parameter int RESET_HOLD = 16,
    parameter int NUM_TIMERS = 4
) (
    input  logic                         clk16,
    input  logic                         resetn,
    input  logic                         loading,
    input  gba_periph_pkg::pad_buttons_t pad_btns,
    input  logic [2:0]                   irq_video,
    input  gba_bus_pkg::io_addr_t        bus_addr,
    input  gba_bus_pkg::io_acc_e         bus_acc,
    input  logic                         bus_rnw,
    input  logic                         bus_ena,
    input  gba_bus_pkg::io_data_t        bus_wdata,
    output gba_bus_pkg::io_data_t        bus_rdata,
    output logic                         bus_done,
    output logic                         cpu_irq,
    output logic                         halt,
    output logic                         gba_on
);

    gba_bus_pkg::io_word_addr_t io_word_addr;
    gba_bus_pkg::io_be_t        io_be;
    logic                       io_wr, io_rd;
    gba_bus_pkg::io_data_t      io_wdata;
    gba_bus_pkg::io_data_t      timer_rdata, irq_rdata, key_rdata;
    logic [NUM_TIMERS-1:0]      timer_irq;
    logic                       key_irq;

    reset_sequencer #(.RESET_HOLD(RESET_HOLD)) rst_seq_i (
        .clk16(clk16), .resetn(resetn), .loading(loading), .gba_on(gba_on)
    );

    io_bus_ctrl bus_i (
        .clk16(clk16), .resetn(resetn),
        .bus_addr(bus_addr), .bus_acc(bus_acc), .bus_rnw(bus_rnw), .bus_ena(bus_ena),
        .bus_wdata(bus_wdata),
        .timer_rdata(timer_rdata), .irq_rdata(irq_rdata), .key_rdata(key_rdata),
        .io_word_addr(io_word_addr), .io_be(io_be), .io_wr(io_wr), .io_rd(io_rd),
        .io_wdata(io_wdata), .bus_rdata(bus_rdata), .bus_done(bus_done)
    );

    interrupt_ctrl #(.NUM_TIMERS(NUM_TIMERS)) intr_i (
        .clk16(clk16), .gba_on(gba_on),
        .io_word_addr(io_word_addr), .io_be(io_be), .io_wr(io_wr), .io_rd(io_rd),
        .io_wdata(io_wdata), .irq_video(irq_video), .timer_irq(timer_irq),
        .key_irq(key_irq), .irq_rdata(irq_rdata), .cpu_irq(cpu_irq), .halt(halt)
    );

    timer_unit #(.NUM_TIMERS(NUM_TIMERS)) timer_i (
        .clk16(clk16), .gba_on(gba_on),
        .io_word_addr(io_word_addr), .io_be(io_be), .io_wr(io_wr), .io_rd(io_rd),
        .io_wdata(io_wdata), .timer_rdata(timer_rdata), .timer_irq(timer_irq)
    );

    keypad_regs keypad_i (
        .clk16(clk16), .gba_on(gba_on), .pad_btns(pad_btns),
        .io_word_addr(io_word_addr), .io_be(io_be), .io_wr(io_wr), .io_rd(io_rd),
        .io_wdata(io_wdata), .key_rdata(key_rdata), .key_irq(key_irq)
    );

endmodule

//--- src/keypad_regs.sv
/*
 * Keypad: pad synchronizer and key mapping, KEYINPUT / KEYCNT,
 * keypad interrupt on the OR / AND condition
 */
`timescale 1ns/1ps

module keypad_regs (
    input  logic                         clk16,
    input  logic                         gba_on,
    input  gba_periph_pkg::pad_buttons_t pad_btns,
    input  gba_bus_pkg::io_word_addr_t   io_word_addr,
    input  gba_bus_pkg::io_be_t          io_be,
    input  logic                         io_wr,
    input  logic                         io_rd,
    input  gba_bus_pkg::io_data_t        io_wdata,
    output gba_bus_pkg::io_data_t        key_rdata,
    output logic                         key_irq
);

    gba_periph_pkg::pad_buttons_t pad_s1, pad_s2;
    gba_periph_pkg::key_state_t   keys, key_mask;
    logic                         irq_en, irq_and;   // KEYCNT bits 14, 15
    logic                         hit, cond_now, cond_q, wr_cnt;

    always_ff @(posedge clk16) begin                 // two-flop synchronizer
        pad_s1 <= pad_btns;
        pad_s2 <= pad_s1;
    end

    // L R DOWN UP LEFT RIGHT START SELECT B A
    assign keys = {pad_s2[10], pad_s2[11], pad_s2[5], pad_s2[4], pad_s2[6],
                   pad_s2[7], pad_s2[3], pad_s2[2], pad_s2[0], pad_s2[8]};

    assign hit      = irq_and ? (|key_mask && (keys & key_mask) == key_mask)
                              : |(keys & key_mask);
    assign cond_now = irq_en && hit;
    assign wr_cnt   = io_wr && io_word_addr == gba_bus_pkg::reg_keyinput;

    always_ff @(posedge clk16) begin
        if (!gba_on) begin
            key_mask  <= '0;
            irq_en    <= 1'b0;
            irq_and   <= 1'b0;
            cond_q    <= 1'b0;
            key_irq   <= 1'b0;
            key_rdata <= '0;
        end else begin
            if (wr_cnt && io_be[2]) key_mask[7:0] <= io_wdata[23:16];
            if (wr_cnt && io_be[3]) begin
                key_mask[9:8] <= io_wdata[25:24];
                irq_en        <= io_wdata[30];
                irq_and       <= io_wdata[31];
            end
            cond_q  <= cond_now;
            key_irq <= cond_now && !cond_q;          // rising edge only
            if (io_rd && io_word_addr == gba_bus_pkg::reg_keyinput)
                key_rdata <= {irq_and, irq_en, 4'b0000, key_mask, 6'b000000, ~keys};
            else
                key_rdata <= '0;
        end
    end

endmodule

//--- src/timer_unit.sv
/*
 * Four cascadable 16-bit timers sharing one prescale counter,
 * with reload, count-up chaining and overflow interrupts
 */
`timescale 1ns/1ps

module timer_unit #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                       clk16,
    input  logic                       gba_on,
    input  gba_bus_pkg::io_word_addr_t io_word_addr,
    input  gba_bus_pkg::io_be_t        io_be,
    input  logic                       io_wr,
    input  logic                       io_rd,
    input  gba_bus_pkg::io_data_t      io_wdata,
    output gba_bus_pkg::io_data_t      timer_rdata,
    output logic [NUM_TIMERS-1:0]      timer_irq
);

    logic [9:0]                   presc;          // shared by all timers
    gba_periph_pkg::timer_count_t cnt_r    [NUM_TIMERS];
    gba_periph_pkg::timer_count_t reload_r [NUM_TIMERS];
    gba_periph_pkg::timer_count_t reload_nx[NUM_TIMERS];
    gba_periph_pkg::timer_ctrl_t  ctrl_r   [NUM_TIMERS];
    logic                         wr_hit   [NUM_TIMERS];
    logic                         start    [NUM_TIMERS];
    logic                         step     [NUM_TIMERS];
    logic                         ovf      [NUM_TIMERS];
    gba_bus_pkg::io_data_t        rd_word;

    function automatic logic presc_tick(input logic [1:0] sel, input logic [9:0] pc);
        case (gba_periph_pkg::prescale_e'(sel))
            gba_periph_pkg::div1:    presc_tick = 1'b1;
            gba_periph_pkg::div64:   presc_tick = (pc[5:0] == '0);
            gba_periph_pkg::div256:  presc_tick = (pc[7:0] == '0);
            gba_periph_pkg::div1024: presc_tick = (pc == '0);
            default:                 presc_tick = 1'b0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // decode, tick select and overflow chain
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic chain;                                  // overflow of timer i-1
        chain   = 1'b0;
        rd_word = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            wr_hit[i] = io_wr &&
                        io_word_addr == gba_bus_pkg::reg_tm0 + gba_bus_pkg::io_word_addr_t'(i);
            reload_nx[i] = reload_r[i];
            if (wr_hit[i] && io_be[0]) reload_nx[i][7:0]  = io_wdata[7:0];
            if (wr_hit[i] && io_be[1]) reload_nx[i][15:8] = io_wdata[15:8];
            start[i] = wr_hit[i] && io_be[2] && io_wdata[23] && !ctrl_r[i][7];

            if (i != 0 && ctrl_r[i][2])
                step[i] = ctrl_r[i][7] && chain;      // count-up
            else
                step[i] = ctrl_r[i][7] && presc_tick(ctrl_r[i][1:0], presc);
            ovf[i] = step[i] && cnt_r[i] == 16'hffff;
            chain  = ovf[i];

            if (io_word_addr == gba_bus_pkg::reg_tm0 + gba_bus_pkg::io_word_addr_t'(i))
                rd_word = {8'h00, ctrl_r[i], cnt_r[i]};
        end
    end

    always_ff @(posedge clk16) begin
        if (!gba_on) begin
            presc       <= '0;
            timer_irq   <= '0;
            timer_rdata <= '0;
            for (int i = 0; i < NUM_TIMERS; i++) begin
                cnt_r[i]    <= '0;
                reload_r[i] <= '0;
                ctrl_r[i]   <= '0;
            end
        end else begin
            presc <= presc + 1'b1;
            for (int i = 0; i < NUM_TIMERS; i++) begin
                reload_r[i] <= reload_nx[i];
                if (wr_hit[i] && io_be[2])
                    ctrl_r[i] <= io_wdata[23:16];
                if (start[i])
                    cnt_r[i] <= reload_nx[i];          // load on enable edge
                else if (ovf[i])
                    cnt_r[i] <= reload_r[i];
                else if (step[i])
                    cnt_r[i] <= cnt_r[i] + 1'b1;
                timer_irq[i] <= ovf[i] && ctrl_r[i][6];
            end
            timer_rdata <= io_rd ? rd_word : '0;
        end
    end

    for (genvar g = 0; g < NUM_TIMERS; g++) begin : g_chk
        a_reload_on_ovf: assert property (@(posedge clk16) disable iff (!gba_on)
            ovf[g] |=> cnt_r[g] == $past(reload_r[g]));
    end

endmodule

//--- src/interrupt_ctrl.sv
/*
 * Interrupt controller: IE, IF, IME and HALTCNT,
 * cpu_irq and the halt state
 */
`timescale 1ns/1ps

module interrupt_ctrl #(
    parameter int NUM_TIMERS = 4
) (
    input  logic                       clk16,
    input  logic                       gba_on,
    input  gba_bus_pkg::io_word_addr_t io_word_addr,
    input  gba_bus_pkg::io_be_t        io_be,
    input  logic                       io_wr,
    input  logic                       io_rd,
    input  gba_bus_pkg::io_data_t      io_wdata,
    input  logic [2:0]                 irq_video,
    input  logic [NUM_TIMERS-1:0]      timer_irq,
    input  logic                       key_irq,
    output gba_bus_pkg::io_data_t      irq_rdata,
    output logic                       cpu_irq,
    output logic                       halt
);

    gba_periph_pkg::irq_vector_t ie_r, if_r, if_clr, irq_src;
    logic                        ime_r;
    logic                        wr_ie, wr_ime, wr_halt;
    logic                        pending;

    assign wr_ie   = io_wr && io_word_addr == gba_bus_pkg::reg_ie;
    assign wr_ime  = io_wr && io_word_addr == gba_bus_pkg::reg_ime;
    assign wr_halt = io_wr && io_word_addr == gba_bus_pkg::reg_haltcnt && io_be[1];
    assign pending = |(ie_r & if_r);

    //////////////////////////////////////////////////////////////////////
    // sources and write-1-to-clear
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        irq_src = '0;
        irq_src[gba_periph_pkg::irq_vblank] = irq_video[0];
        irq_src[gba_periph_pkg::irq_hblank] = irq_video[1];
        irq_src[gba_periph_pkg::irq_vcount] = irq_video[2];
        for (int i = 0; i < NUM_TIMERS; i++)
            irq_src[gba_periph_pkg::irq_timer0 + i] = timer_irq[i];
        irq_src[gba_periph_pkg::irq_keypad] = key_irq;

        if_clr = '0;
        if (wr_ie && io_be[2]) if_clr[7:0]  = io_wdata[23:16];
        if (wr_ie && io_be[3]) if_clr[13:8] = io_wdata[29:24];
    end

    always_ff @(posedge clk16) begin
        if (!gba_on) begin
            ie_r      <= '0;
            if_r      <= '0;
            ime_r     <= 1'b0;
            cpu_irq   <= 1'b0;
            halt      <= 1'b0;
            irq_rdata <= '0;
        end else begin
            if (wr_ie && io_be[0]) ie_r[7:0]  <= io_wdata[7:0];
            if (wr_ie && io_be[1]) ie_r[13:8] <= io_wdata[13:8];
            if (wr_ime && io_be[0]) ime_r <= io_wdata[0];
            if_r    <= (if_r & ~if_clr) | irq_src;   // new pulse beats the clear
            cpu_irq <= ime_r & pending;

            if (wr_halt)
                halt <= 1'b1;
            else if (pending)                         // wake ignores IME
                halt <= 1'b0;

            if (io_rd && io_word_addr == gba_bus_pkg::reg_ie)
                irq_rdata <= {2'b00, if_r, 2'b00, ie_r};
            else if (io_rd && io_word_addr == gba_bus_pkg::reg_ime)
                irq_rdata <= {31'd0, ime_r};
            else
                irq_rdata <= '0;                      // HALTCNT reads as zero
        end
    end

    // cpu_irq trails an IME write by one cycle
    a_irq_needs_ime: assert property (@(posedge clk16) disable iff (!gba_on)
        cpu_irq |-> ime_r || $past(wr_ime && io_be[0]));

endmodule

//--- src/io_bus_ctrl.sv
/*
 * Bus access path: byte lanes from size and offset, peripheral
 * strobes, read-word merge and the done pulse
 */
`timescale 1ns/1ps

module io_bus_ctrl (
    input  logic                       clk16,
    input  logic                       resetn,
    input  gba_bus_pkg::io_addr_t      bus_addr,
    input  gba_bus_pkg::io_acc_e       bus_acc,
    input  logic                       bus_rnw,
    input  logic                       bus_ena,
    input  gba_bus_pkg::io_data_t      bus_wdata,
    input  gba_bus_pkg::io_data_t      timer_rdata,
    input  gba_bus_pkg::io_data_t      irq_rdata,
    input  gba_bus_pkg::io_data_t      key_rdata,
    output gba_bus_pkg::io_word_addr_t io_word_addr,
    output gba_bus_pkg::io_be_t        io_be,
    output logic                       io_wr,
    output logic                       io_rd,
    output gba_bus_pkg::io_data_t      io_wdata,
    output gba_bus_pkg::io_data_t      bus_rdata,
    output logic                       bus_done
);

    always_comb begin
        case (bus_acc)
            gba_bus_pkg::acc_byte: io_be = 4'b0001 << bus_addr[1:0];
            gba_bus_pkg::acc_half: io_be = bus_addr[1] ? 4'b1100 : 4'b0011;
            gba_bus_pkg::acc_word: io_be = 4'b1111;
            default:               io_be = 4'b0000;
        endcase
    end

    assign io_word_addr = bus_addr[9:2];
    assign io_wdata     = bus_wdata;            // already on its lanes
    assign io_wr        = bus_ena & ~bus_rnw;
    assign io_rd        = bus_ena & bus_rnw;

    // unselected peripherals return zero, so a plain OR merges them
    assign bus_rdata = timer_rdata | irq_rdata | key_rdata;

    always_ff @(posedge clk16) begin
        if (!resetn)
            bus_done <= 1'b0;
        else
            bus_done <= bus_ena;
    end

    a_half_aligned: assert property (@(posedge clk16) disable iff (!resetn)
        bus_ena && bus_acc == gba_bus_pkg::acc_half |-> !bus_addr[0]);
    a_word_aligned: assert property (@(posedge clk16) disable iff (!resetn)
        bus_ena && bus_acc == gba_bus_pkg::acc_word |-> bus_addr[1:0] == 2'b00);

endmodule

//--- src/reset_sequencer.sv
/* Power-on hold counter producing gba_on */
`timescale 1ns/1ps

module reset_sequencer #(
    parameter int RESET_HOLD = 16
) (
    input  logic clk16,
    input  logic resetn,
    input  logic loading,
    output logic gba_on
);

    localparam int CW = $clog2(RESET_HOLD + 2);

    logic [CW-1:0] hold_cnt;

    always_ff @(posedge clk16) begin
        if (!resetn || loading) begin       // loading keeps the core off too
            hold_cnt <= CW'(RESET_HOLD);
            gba_on   <= 1'b0;
        end else begin
            if (hold_cnt != '0)
                hold_cnt <= hold_cnt - 1'b1;
            gba_on <= (hold_cnt == '0);
        end
    end

endmodule

//--- src/gba_periph_pkg.sv
/*
 * Peripheral types: interrupt bit indices, timer fields,
 * prescaler select and the pad / key vectors
 */

package gba_periph_pkg;

    typedef logic [13:0] irq_vector_t;

    // positions in IE / IF
    localparam int irq_vblank = 0;
    localparam int irq_hblank = 1;
    localparam int irq_vcount = 2;
    localparam int irq_timer0 = 3;   // timer n at 3+n
    localparam int irq_keypad = 12;

    typedef logic [15:0] timer_count_t;
    typedef logic [7:0]  timer_ctrl_t;  // 7 enable, 6 irq, 2 count-up, 1:0 prescale

    typedef enum logic [1:0] {
        div1    = 2'd0,
        div64   = 2'd1,
        div256  = 2'd2,
        div1024 = 2'd3
    } prescale_e;

    // R L X A RT LT DN UP START SELECT Y B, msb first
    typedef logic [11:0] pad_buttons_t;
    // A B SELECT START RIGHT LEFT UP DOWN R L, lsb first
    typedef logic [9:0]  key_state_t;

endpackage

//--- src/gba_bus_pkg.sv
/*
 * I/O bus types: offsets, data, byte lanes and access size,
 * plus the word indices of the mapped register pairs
 */

package gba_bus_pkg;

    typedef logic [9:0]  io_addr_t;        // byte offset in the I/O region
    typedef logic [7:0]  io_word_addr_t;   // byte offset without bits 1:0
    typedef logic [31:0] io_data_t;
    typedef logic [3:0]  io_be_t;          // one bit per byte lane

    typedef enum logic [1:0] {
        acc_byte = 2'd0,
        acc_half = 2'd1,
        acc_word = 2'd2
    } io_acc_e;

    //////////////////////////////////////////////////////////////////////
    // register pairs, as word indices
    //////////////////////////////////////////////////////////////////////

    localparam io_word_addr_t reg_tm0      = 8'h40; // 0x100, timer n at +n
    localparam io_word_addr_t reg_keyinput = 8'h4c; // 0x130, KEYCNT in upper half
    localparam io_word_addr_t reg_ie       = 8'h80; // 0x200, IF in upper half
    localparam io_word_addr_t reg_ime      = 8'h82; // 0x208
    localparam io_word_addr_t reg_haltcnt  = 8'hc0; // 0x300, HALTCNT in lane 1

endpackage
